/* hdl/ion_pkg.sv */
package ion_pkg;

	localparam int index_width = 6;
	localparam int interval_width = 16;
	localparam int packet_width = 110;

	typedef logic [index_width-1:0] packet_index_t; // table position 0 to 59
	typedef logic [interval_width-1:0] interval_t;

	typedef struct packed
	{
		logic [23:0] device_id;
		logic [5:0] channel;
		logic [15:0] sample_word;
		logic [7:0] tag_low;
		logic [7:0] tag_high;
		logic [15:0] sequence_word;
		logic [7:0] gain_byte;
		logic [7:0] level_byte;
		logic [7:0] marker_byte;
		logic status_flag;
		logic [6:0] sync_code; // least significant bits of the packet
	} ion_packet_t;

	// only these fields change from one recorded packet to the next
	typedef struct packed
	{
		logic status_flag;
		logic [7:0] level_byte;
		logic [7:0] gain_byte;
		logic [15:0] sequence_word;
		logic [15:0] sample_word;
	} sample_fields_t;

	localparam logic [6:0] sync_value = 7'd77;
	localparam logic [7:0] marker_value = 8'd255;
	localparam logic [7:0] tag_high_value = 8'd239;
	localparam logic [7:0] tag_low_value = 8'd17;
	localparam logic [5:0] channel_value = 6'd1;
	localparam logic [23:0] device_id_value = 24'd4272433;

	localparam int packet_count = 60; // the index wraps here
	localparam interval_t default_interval = 16'haaaa;

	typedef enum logic [1:0] {state_start, state_idle, state_read, state_send} pacer_state_t;

endpackage

/* hdl/packet_pacer.sv */
`timescale 1ns/1ns

module packet_pacer
#(
	parameter ion_pkg::interval_t interval = ion_pkg::default_interval
)
(
	input logic clock,
	input logic resetn,
	output logic read_strobe,
	output logic send
);
	import ion_pkg::*;

	pacer_state_t state;
	pacer_state_t state_next;
	interval_t timer;
	logic timer_done;

	assign timer_done = (timer == interval);

	// the timer only runs while waiting, so idle lasts interval+1 cycles
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			timer <= '0;
		else if (state == state_read)
			timer <= '0;
		else if (state == state_idle)
			timer <= timer + 16'd1;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			state_start:
				state_next = state_idle;
			state_idle:
			begin
				if (timer_done)
					state_next = state_read;
			end
			state_read:
				state_next = state_send; // one cycle for the table lookup
			state_send:
				state_next = state_idle;
			default:
				state_next = state_start;
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			state <= state_start;
		else
			state <= state_next;
	end

	assign read_strobe = (state == state_read);
	assign send = (state == state_send); // doubles as packet_valid at the top

endmodule

/* hdl/packet_rom.sv */
`timescale 1ns/1ns

module packet_rom
(
	input logic clock,
	input logic resetn,
	input logic read_strobe,
	input logic send,
	output ion_pkg::ion_packet_t packet_data
);
	import ion_pkg::*;

	packet_index_t index;
	sample_fields_t entry;
	ion_packet_t assembled;
	ion_packet_t packet_reg;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			index <= '0;
		else if (read_strobe)
		begin
			if (index == packet_index_t'(packet_count - 1))
				index <= '0;
			else
				index <= index + 6'd1;
		end
	end

	// status, level, gain, sequence, sample
	always_comb
	begin
		case (index)
			6'd0: entry = {1'b0, 8'd177, 8'd100, 16'd881, 16'd56110};
			6'd1: entry = {1'b1, 8'd176, 8'd100, 16'd925, 16'd3791};
			6'd2: entry = {1'b0, 8'd177, 8'd100, 16'd962, 16'd63275};
			6'd3: entry = {1'b1, 8'd177, 8'd100, 16'd1011, 16'd24574};
			6'd4: entry = {1'b1, 8'd185, 8'd100, 16'd1045, 16'd40019};
			6'd5: entry = {1'b1, 8'd186, 8'd100, 16'd1094, 16'd50527};
			6'd6: entry = {1'b0, 8'd177, 8'd100, 16'd1136, 16'd60177};
			6'd7: entry = {1'b0, 8'd178, 8'd100, 16'd1178, 16'd47222};
			6'd8: entry = {1'b0, 8'd177, 8'd100, 16'd1220, 16'd42756};
			6'd9: entry = {1'b0, 8'd177, 8'd100, 16'd1262, 16'd61961};
			6'd10: entry = {1'b0, 8'd183, 8'd100, 16'd1304, 16'd7993};
			6'd11: entry = {1'b0, 8'd178, 8'd100, 16'd1346, 16'd17675};
			6'd12: entry = {1'b0, 8'd178, 8'd100, 16'd1380, 16'd57473};
			6'd13: entry = {1'b0, 8'd177, 8'd100, 16'd1430, 16'd53224};
			6'd14: entry = {1'b0, 8'd178, 8'd100, 16'd1472, 16'd61195};
			6'd15: entry = {1'b1, 8'd185, 8'd100, 16'd1514, 16'd46996};
			6'd16: entry = {1'b1, 8'd177, 8'd100, 16'd1556, 16'd145};
			6'd17: entry = {1'b1, 8'd178, 8'd100, 16'd1598, 16'd21191};
			6'd18: entry = {1'b0, 8'd177, 8'd100, 16'd1635, 16'd610};
			6'd19: entry = {1'b1, 8'd177, 8'd100, 16'd1679, 16'd4089};
			6'd20: entry = {1'b0, 8'd178, 8'd100, 16'd1729, 16'd20685};
			6'd21: entry = {1'b1, 8'd177, 8'd100, 16'd1766, 16'd10459};
			6'd22: entry = {1'b1, 8'd178, 8'd100, 16'd1815, 16'd57766};
			6'd23: entry = {1'b0, 8'd177, 8'd100, 16'd1857, 16'd48236};
			6'd24: entry = {1'b1, 8'd177, 8'd100, 16'd1903, 16'd36453};
			6'd25: entry = {1'b0, 8'd183, 8'd100, 16'd1945, 16'd22977};
			6'd26: entry = {1'b0, 8'd177, 8'd100, 16'd1987, 16'd13045};
			6'd27: entry = {1'b0, 8'd177, 8'd100, 16'd2033, 16'd40993};
			6'd28: entry = {1'b1, 8'd177, 8'd100, 16'd2075, 16'd45310};
			6'd29: entry = {1'b1, 8'd177, 8'd100, 16'd2108, 16'd62988};
			6'd30: entry = {1'b1, 8'd177, 8'd101, 16'd2162, 16'd50032};
			6'd31: entry = {1'b1, 8'd178, 8'd100, 16'd2199, 16'd22312};
			6'd32: entry = {1'b0, 8'd177, 8'd100, 16'd2248, 16'd48507};
			6'd33: entry = {1'b0, 8'd178, 8'd101, 16'd2286, 16'd3615};
			6'd34: entry = {1'b1, 8'd177, 8'd100, 16'd2335, 16'd31043};
			6'd35: entry = {1'b0, 8'd177, 8'd100, 16'd2381, 16'd65151};
			6'd36: entry = {1'b0, 8'd177, 8'd100, 16'd2423, 16'd45123};
			6'd37: entry = {1'b0, 8'd177, 8'd100, 16'd2465, 16'd47297};
			6'd38: entry = {1'b0, 8'd177, 8'd100, 16'd2498, 16'd1374};
			6'd39: entry = {1'b0, 8'd180, 8'd100, 16'd2548, 16'd8510};
			6'd40: entry = {1'b1, 8'd178, 8'd100, 16'd2581, 16'd3766};
			6'd41: entry = {1'b0, 8'd178, 8'd100, 16'd2631, 16'd15678};
			6'd42: entry = {1'b0, 8'd178, 8'd100, 16'd2670, 16'd46144};
			6'd43: entry = {1'b1, 8'd176, 8'd100, 16'd2712, 16'd43275};
			6'd44: entry = {1'b1, 8'd185, 8'd100, 16'd2758, 16'd6402};
			6'd45: entry = {1'b0, 8'd178, 8'd100, 16'd2800, 16'd28324};
			6'd46: entry = {1'b0, 8'd177, 8'd100, 16'd2842, 16'd41123};
			6'd47: entry = {1'b0, 8'd178, 8'd100, 16'd2888, 16'd25754};
			6'd48: entry = {1'b1, 8'd177, 8'd100, 16'd2926, 16'd43754};
			6'd49: entry = {1'b0, 8'd177, 8'd100, 16'd2973, 16'd37758};
			6'd50: entry = {1'b0, 8'd177, 8'd100, 16'd3015, 16'd62364};
			6'd51: entry = {1'b1, 8'd177, 8'd100, 16'd3057, 16'd48200};
			6'd52: entry = {1'b1, 8'd178, 8'd100, 16'd3100, 16'd56276};
			6'd53: entry = {1'b0, 8'd178, 8'd100, 16'd3146, 16'd59933};
			6'd54: entry = {1'b0, 8'd177, 8'd101, 16'd3184, 16'd30250};
			6'd55: entry = {1'b1, 8'd178, 8'd100, 16'd3233, 16'd49966};
			6'd56: entry = {1'b1, 8'd177, 8'd100, 16'd3267, 16'd662};
			6'd57: entry = {1'b1, 8'd178, 8'd100, 16'd3308, 16'd47031};
			6'd58: entry = {1'b1, 8'd178, 8'd100, 16'd3349, 16'd2734};
			6'd59: entry = {1'b0, 8'd177, 8'd101, 16'd3390, 16'd36121};
			default: entry = '0; // the index never gets past 59
		endcase
	end

	always_comb
	begin
		assembled.device_id = device_id_value;
		assembled.channel = channel_value;
		assembled.sample_word = entry.sample_word;
		assembled.tag_low = tag_low_value;
		assembled.tag_high = tag_high_value;
		assembled.sequence_word = entry.sequence_word;
		assembled.gain_byte = entry.gain_byte;
		assembled.level_byte = entry.level_byte;
		assembled.marker_byte = marker_value;
		assembled.status_flag = entry.status_flag;
		assembled.sync_code = sync_value;
	end

	always_ff @(posedge clock)
	begin
		if (read_strobe)
			packet_reg <= assembled;
	end

	assign packet_data = send ? packet_reg : {packet_width{1'b0}}; // bus reads zero between packets

endmodule

/* hdl/ion_sensor_top.sv */
`timescale 1ns/1ns

module ion_sensor_top
#(
	parameter ion_pkg::interval_t interval = ion_pkg::default_interval
)
(
	input logic clock,
	input logic resetn,
	output logic packet_valid,
	output ion_pkg::ion_packet_t packet_data
);

	logic read_strobe;

	// the send level of the pacer is the valid pulse seen outside
	packet_pacer
	#(
		.interval(interval)
	)
	u_pacer
	(
		.clock(clock),
		.resetn(resetn),
		.read_strobe(read_strobe),
		.send(packet_valid)
	);

	packet_rom u_rom
	(
		.clock(clock),
		.resetn(resetn),
		.read_strobe(read_strobe),
		.send(packet_valid),
		.packet_data(packet_data)
	);

endmodule

/* sim/ion_expected_table.svh */
	// one entry per recorded packet, in send order
	// the columns are status_flag, level_byte, gain_byte, sequence_word and sample_word
	sample_fields_t expected_fields [packet_count];

	task automatic load_expected_table();
		expected_fields[0] = {1'b0, 8'd177, 8'd100, 16'd881, 16'd56110};
		expected_fields[1] = {1'b1, 8'd176, 8'd100, 16'd925, 16'd3791};
		expected_fields[2] = {1'b0, 8'd177, 8'd100, 16'd962, 16'd63275};
		expected_fields[3] = {1'b1, 8'd177, 8'd100, 16'd1011, 16'd24574};
		expected_fields[4] = {1'b1, 8'd185, 8'd100, 16'd1045, 16'd40019};
		expected_fields[5] = {1'b1, 8'd186, 8'd100, 16'd1094, 16'd50527};
		expected_fields[6] = {1'b0, 8'd177, 8'd100, 16'd1136, 16'd60177};
		expected_fields[7] = {1'b0, 8'd178, 8'd100, 16'd1178, 16'd47222};
		expected_fields[8] = {1'b0, 8'd177, 8'd100, 16'd1220, 16'd42756};
		expected_fields[9] = {1'b0, 8'd177, 8'd100, 16'd1262, 16'd61961};
		expected_fields[10] = {1'b0, 8'd183, 8'd100, 16'd1304, 16'd7993};
		expected_fields[11] = {1'b0, 8'd178, 8'd100, 16'd1346, 16'd17675};
		expected_fields[12] = {1'b0, 8'd178, 8'd100, 16'd1380, 16'd57473};
		expected_fields[13] = {1'b0, 8'd177, 8'd100, 16'd1430, 16'd53224};
		expected_fields[14] = {1'b0, 8'd178, 8'd100, 16'd1472, 16'd61195};
		expected_fields[15] = {1'b1, 8'd185, 8'd100, 16'd1514, 16'd46996};
		expected_fields[16] = {1'b1, 8'd177, 8'd100, 16'd1556, 16'd145};
		expected_fields[17] = {1'b1, 8'd178, 8'd100, 16'd1598, 16'd21191};
		expected_fields[18] = {1'b0, 8'd177, 8'd100, 16'd1635, 16'd610};
		expected_fields[19] = {1'b1, 8'd177, 8'd100, 16'd1679, 16'd4089};
		expected_fields[20] = {1'b0, 8'd178, 8'd100, 16'd1729, 16'd20685};
		expected_fields[21] = {1'b1, 8'd177, 8'd100, 16'd1766, 16'd10459};
		expected_fields[22] = {1'b1, 8'd178, 8'd100, 16'd1815, 16'd57766};
		expected_fields[23] = {1'b0, 8'd177, 8'd100, 16'd1857, 16'd48236};
		expected_fields[24] = {1'b1, 8'd177, 8'd100, 16'd1903, 16'd36453};
		expected_fields[25] = {1'b0, 8'd183, 8'd100, 16'd1945, 16'd22977};
		expected_fields[26] = {1'b0, 8'd177, 8'd100, 16'd1987, 16'd13045};
		expected_fields[27] = {1'b0, 8'd177, 8'd100, 16'd2033, 16'd40993};
		expected_fields[28] = {1'b1, 8'd177, 8'd100, 16'd2075, 16'd45310};
		expected_fields[29] = {1'b1, 8'd177, 8'd100, 16'd2108, 16'd62988};
		expected_fields[30] = {1'b1, 8'd177, 8'd101, 16'd2162, 16'd50032};
		expected_fields[31] = {1'b1, 8'd178, 8'd100, 16'd2199, 16'd22312};
		expected_fields[32] = {1'b0, 8'd177, 8'd100, 16'd2248, 16'd48507};
		expected_fields[33] = {1'b0, 8'd178, 8'd101, 16'd2286, 16'd3615};
		expected_fields[34] = {1'b1, 8'd177, 8'd100, 16'd2335, 16'd31043};
		expected_fields[35] = {1'b0, 8'd177, 8'd100, 16'd2381, 16'd65151};
		expected_fields[36] = {1'b0, 8'd177, 8'd100, 16'd2423, 16'd45123};
		expected_fields[37] = {1'b0, 8'd177, 8'd100, 16'd2465, 16'd47297};
		expected_fields[38] = {1'b0, 8'd177, 8'd100, 16'd2498, 16'd1374};
		expected_fields[39] = {1'b0, 8'd180, 8'd100, 16'd2548, 16'd8510};
		expected_fields[40] = {1'b1, 8'd178, 8'd100, 16'd2581, 16'd3766};
		expected_fields[41] = {1'b0, 8'd178, 8'd100, 16'd2631, 16'd15678};
		expected_fields[42] = {1'b0, 8'd178, 8'd100, 16'd2670, 16'd46144};
		expected_fields[43] = {1'b1, 8'd176, 8'd100, 16'd2712, 16'd43275};
		expected_fields[44] = {1'b1, 8'd185, 8'd100, 16'd2758, 16'd6402};
		expected_fields[45] = {1'b0, 8'd178, 8'd100, 16'd2800, 16'd28324};
		expected_fields[46] = {1'b0, 8'd177, 8'd100, 16'd2842, 16'd41123};
		expected_fields[47] = {1'b0, 8'd178, 8'd100, 16'd2888, 16'd25754};
		expected_fields[48] = {1'b1, 8'd177, 8'd100, 16'd2926, 16'd43754};
		expected_fields[49] = {1'b0, 8'd177, 8'd100, 16'd2973, 16'd37758};
		expected_fields[50] = {1'b0, 8'd177, 8'd100, 16'd3015, 16'd62364};
		expected_fields[51] = {1'b1, 8'd177, 8'd100, 16'd3057, 16'd48200};
		expected_fields[52] = {1'b1, 8'd178, 8'd100, 16'd3100, 16'd56276};
		expected_fields[53] = {1'b0, 8'd178, 8'd100, 16'd3146, 16'd59933};
		expected_fields[54] = {1'b0, 8'd177, 8'd101, 16'd3184, 16'd30250};
		expected_fields[55] = {1'b1, 8'd178, 8'd100, 16'd3233, 16'd49966};
		expected_fields[56] = {1'b1, 8'd177, 8'd100, 16'd3267, 16'd662};
		expected_fields[57] = {1'b1, 8'd178, 8'd100, 16'd3308, 16'd47031};
		expected_fields[58] = {1'b1, 8'd178, 8'd100, 16'd3349, 16'd2734};
		expected_fields[59] = {1'b0, 8'd177, 8'd101, 16'd3390, 16'd36121};
	endtask

/* sim/tb_ion_sensor.sv */
`timescale 1ns/1ns

module tb_ion_sensor;
	import ion_pkg::*;

	localparam interval_t test_interval = 16'd12;
	localparam int packet_period = test_interval + 3; // interval+1 idle cycles plus read and send
	localparam int reset_cycles = 5;
	localparam int clock_period = 100;
	localparam int watchdog_cycles = 5 + 3 * 61 * 15 + 200;

	logic clock;
	logic resetn;
	logic packet_valid;
	ion_packet_t packet_data;

	int errors;
	int checks;
	int cycle_count; // counts from the last release of resetn
	logic [7:0] lfsr_state;

	`include "ion_expected_table.svh"

	ion_sensor_top
	#(
		.interval(test_interval)
	)
	u_dut
	(
		.clock(clock),
		.resetn(resetn),
		.packet_valid(packet_valid),
		.packet_data(packet_data)
	);

	always
	begin
		#50 clock = ~clock;
	end

	// taps 8, 6, 5 and 4 give a maximal length sequence
	function automatic logic [7:0] next_lfsr(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	task automatic take_random_bits(input int bit_count, output int value);
		int i;
		value = 0;
		for (i = 0; i < bit_count; i++)
		begin
			lfsr_state = next_lfsr(lfsr_state);
			value = (value << 1) | lfsr_state[0];
		end
	endtask

	function automatic ion_packet_t expected_packet(input int entry_index);
		ion_packet_t packet;
		sample_fields_t fields;
		fields = expected_fields[entry_index];
		packet.device_id = device_id_value;
		packet.channel = channel_value;
		packet.sample_word = fields.sample_word;
		packet.tag_low = tag_low_value;
		packet.tag_high = tag_high_value;
		packet.sequence_word = fields.sequence_word;
		packet.gain_byte = fields.gain_byte;
		packet.level_byte = fields.level_byte;
		packet.marker_byte = marker_value;
		packet.status_flag = fields.status_flag;
		packet.sync_code = sync_value;
		return packet;
	endfunction

	task automatic check_valid(input string name, input logic actual, input logic expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERR %s: got %h, expected %h at %0t ns", name, actual, expected, $time);
		end
	endtask

	task automatic check_packet(input string name, input ion_packet_t actual,
		input ion_packet_t expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERR %s: got %h, expected %h at %0t ns", name, actual, expected, $time);
		end
	endtask

	task automatic step_cycle();
		@(negedge clock);
		cycle_count++;
	endtask

	task automatic apply_reset();
		int i;
		resetn = 1'b0;
		for (i = 0; i < reset_cycles; i++)
		begin
			@(negedge clock);
			check_valid("packet_valid", packet_valid, 1'b0);
			check_packet("packet_data", packet_data, '0);
		end
		resetn = 1'b1;
		cycle_count = 0;
	endtask

	// packet n after a reset is due in cycle 15*(n+1) and the bus reads zero until then
	task automatic receive_packet(input int packet_number);
		int due_cycle;
		bit seen;
		due_cycle = packet_period * (packet_number + 1);
		seen = 1'b0;
		while (!seen && cycle_count < due_cycle + packet_period)
		begin
			step_cycle();
			if (packet_valid === 1'b1)
				seen = 1'b1;
			else
				check_packet("packet_data", packet_data, '0);
		end
		if (!seen)
		begin
			errors++;
			$display("packet %0d never arrived, packet_valid stayed low up to cycle %0d",
				packet_number, cycle_count);
		end
		else
		begin
			if (cycle_count != due_cycle)
			begin
				errors++;
				$display("packet %0d arrived in cycle %0d instead of cycle %0d",
					packet_number, cycle_count, due_cycle);
			end
			check_packet("packet_data", packet_data, expected_packet(packet_number % packet_count));
		end
	endtask

	task automatic test_reset_state();
		int i;
		apply_reset();
		for (i = 1; i < packet_period; i++)
		begin
			step_cycle();
			check_valid("packet_valid", packet_valid, 1'b0);
			check_packet("packet_data", packet_data, '0);
		end
	endtask

	task automatic test_pacing();
		int i;
		for (i = 0; i < 3; i++)
		begin
			receive_packet(i);
			step_cycle();
			check_valid("packet_valid", packet_valid, 1'b0); // the pulse lasts one cycle
			check_packet("packet_data", packet_data, '0);
		end
	endtask

	task automatic test_contents();
		int i;
		for (i = 3; i < packet_count; i++)
			receive_packet(i);
	endtask

	task automatic test_wrap();
		receive_packet(packet_count); // the 61st packet comes from entry 0 again
		receive_packet(packet_count + 1);
		receive_packet(packet_count + 2);
	endtask

	task automatic test_restart();
		int offset;
		int i;
		take_random_bits(4, offset);
		offset = 1 + offset % 13; // lands in the idle gap before the next packet
		$display("reset asserted %0d cycles after packet %0d", offset, packet_count + 3);
		for (i = 0; i < offset; i++)
		begin
			step_cycle();
			check_valid("packet_valid", packet_valid, 1'b0);
			check_packet("packet_data", packet_data, '0);
		end
		apply_reset();
		receive_packet(0);
		receive_packet(1);
	endtask

	initial
	begin
		clock = 1'b0;
		resetn = 1'b0;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		lfsr_state = 8'd58;
		load_expected_table();
		test_reset_state();
		test_pacing();
		test_contents();
		test_wrap();
		test_restart();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		#(watchdog_cycles * clock_period);
		$display("timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* ion_sensor.f */
+incdir+sim
hdl/ion_pkg.sv
hdl/packet_pacer.sv
hdl/packet_rom.sv
hdl/ion_sensor_top.sv
sim/tb_ion_sensor.sv
